/* hdl/rider_status_cfg.svh */
`ifndef RIDER_STATUS_CFG_SVH
`define RIDER_STATUS_CFG_SVH

// Firmware revision reported in status word 0
`define MAJOR_REV 8'd1
`define MINOR_REV 8'd4
`define PATCH_REV 8'd2

// Number of 32-bit status words in the map
`define STATUS_REG_COUNT 21

`endif

/* hdl/status_pkg.sv */
package status_pkg;

  // Hard errors raised outside the counters
  typedef struct packed {
    logic       trig_num_from_tt;
    logic       trig_type_from_tt;
    logic       trig_num_from_cm;
    logic       trig_type_from_cm;
    logic       pll_unlock;
    logic       trig_rate;
    logic [4:0] chan_error_rc;
  } hard_err_t;

  typedef struct packed {
    logic daq_clk_sel;
    logic daq_clk_en;
    logic adcclk_clkin1_stat;
    logic adcclk_clkin0_stat;
    logic adcclk_stat_ld;
    logic adcclk_stat;
  } clk_stat_t;

  // DAQ link and TTC/TTS
  typedef struct packed {
    logic       daq_almost_full;
    logic       daq_ready;
    logic [3:0] tts_state;
    logic [5:0] ttc_chan_b_info;
    logic       ttc_ready;
  } link_stat_t;

  typedef struct packed {
    logic [33:0] cm_state;
    logic [3:0]  ttr;
    logic [3:0]  ptr;
    logic [3:0]  cac;
    logic [3:0]  caca;
    logic [3:0]  pc;
    logic [6:0]  tp;
  } fsm_stat_t;

  typedef struct packed {
    logic [4:0] acq_readout_pause;
    logic [4:0] fill_type;
    logic [4:0] chan_en;
    logic [4:0] acq_dones;
    logic       endianness_sel;
    logic       trig_fifo_full;
    logic       acq_fifo_full;
    logic [2:0] trig_settings;
  } acq_stat_t;

  typedef struct packed {
    logic        prog_chan_done;
    logic        async_mode;
    logic [11:0] i2c_temp;
    logic [31:0] trig_delay;
  } board_stat_t;

  // Count and host threshold per soft error
  typedef struct packed {
    logic [31:0] data_corrupt_count;
    logic [31:0] data_corrupt_thres;
    logic [31:0] unknown_ttc_count;
    logic [31:0] unknown_ttc_thres;
    logic [31:0] ddr3_overflow_count;
    logic [31:0] ddr3_overflow_thres;
  } soft_err_t;

  typedef struct packed {
    logic [23:0] trig_num;
    logic [43:0] trig_timestamp;
    logic [23:0] pulse_trig_num;
  } trig_info_t;

endpackage

/* hdl/regbus_pkg.sv */
package regbus_pkg;

  // Read request, valid while req is high
  typedef struct packed {
    logic [4:0] addr;
  } rd_req_t;

  // Read response, valid while ack is high
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } rd_rsp_t;

endpackage

/* hdl/soft_error_counter.sv */
`timescale 1ns/10ps

module soft_error_counter (
  input  logic        clk,
  input  logic        reset,
  input  logic        event_pulse,
  input  logic [31:0] threshold,
  output logic [31:0] count,
  output logic        flag
);

  logic [31:0] count_next;
  logic        over_thres;

  // Saturating increment
  always_comb begin
    count_next = count;
    if (event_pulse && (count != 32'hffff_ffff)) begin
      count_next = count + 32'd1;
    end
  end

  // Zero threshold disables the flag
  assign over_thres = (threshold != 32'd0) && (count_next >= threshold);

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= 32'd0;
      flag  <= 1'b0;
    end else begin
      count <= count_next;
      // Sticky until reset
      if (over_thres) begin
        flag <= 1'b1;
      end
    end
  end

endmodule

/* hdl/trigger_tracker.sv */
`timescale 1ns/10ps

module trigger_tracker (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   trig,
  input  logic                   pulse_trig,
  output status_pkg::trig_info_t info
);

  // Free-running time base
  logic [43:0] timestamp;

  always_ff @(posedge clk) begin
    if (reset) begin
      timestamp <= 44'd0;
    end else begin
      timestamp <= timestamp + 44'd1;
    end
  end

  // TTC trigger count and timestamp capture
  always_ff @(posedge clk) begin
    if (reset) begin
      info.trig_num       <= 24'd0;
      info.trig_timestamp <= 44'd0;
    end else if (trig) begin
      info.trig_num       <= info.trig_num + 24'd1;
      // Value before this edge's increment
      info.trig_timestamp <= timestamp;
    end
  end

  // Front panel triggers
  always_ff @(posedge clk) begin
    if (reset) begin
      info.pulse_trig_num <= 24'd0;
    end else if (pulse_trig) begin
      info.pulse_trig_num <= info.pulse_trig_num + 24'd1;
    end
  end

endmodule

/* hdl/status_reg_block.sv */
`timescale 1ns/10ps
`include "rider_status_cfg.svh"

module status_reg_block (
  input  status_pkg::hard_err_t   hard_err,
  input  status_pkg::clk_stat_t   clk_stat,
  input  status_pkg::link_stat_t  link_stat,
  input  status_pkg::fsm_stat_t   fsm_stat,
  input  status_pkg::acq_stat_t   acq_stat,
  input  status_pkg::board_stat_t board_stat,
  input  status_pkg::soft_err_t   soft_err,
  input  status_pkg::trig_info_t  trig_info,
  input  logic                    err_data_corrupt,
  input  logic                    err_unknown_ttc,
  input  logic                    ddr3_overflow_warning,
  output logic [31:0]             status_regs [`STATUS_REG_COUNT]
);

  // FPGA status and firmware revision
  assign status_regs[0] = {1'b0, board_stat.prog_chan_done, board_stat.async_mode, 5'd0,
                           `MAJOR_REV, `MINOR_REV, `PATCH_REV};

  // Hard errors and the DDR3 warning
  assign status_regs[1] = {18'd0, ddr3_overflow_warning, hard_err.chan_error_rc,
                           hard_err.trig_type_from_cm, hard_err.trig_type_from_tt,
                           hard_err.trig_num_from_cm, hard_err.trig_num_from_tt,
                           err_data_corrupt, hard_err.trig_rate, err_unknown_ttc,
                           hard_err.pll_unlock};

  // External clock, temperature in the top bits
  assign status_regs[2] = {board_stat.i2c_temp, 18'd0, clk_stat.daq_clk_sel,
                           clk_stat.daq_clk_en};

  assign status_regs[3] = {28'd0, clk_stat.adcclk_clkin1_stat, clk_stat.adcclk_clkin0_stat,
                           clk_stat.adcclk_stat_ld, clk_stat.adcclk_stat};

  assign status_regs[4] = {30'd0, link_stat.daq_almost_full, link_stat.daq_ready};

  // TTC/TTS
  assign status_regs[5] = {21'd0, link_stat.tts_state, link_stat.ttc_chan_b_info,
                           link_stat.ttc_ready};

  // cm_state spills its top two bits into word 7
  assign status_regs[6] = fsm_stat.cm_state[31:0];
  assign status_regs[7] = {3'd0, fsm_stat.cm_state[33:32], fsm_stat.pc, fsm_stat.tp,
                           fsm_stat.caca, fsm_stat.cac, fsm_stat.ptr, fsm_stat.ttr};

  // Acquisition
  assign status_regs[8] = {11'd0, acq_stat.acq_dones, acq_stat.endianness_sel,
                           acq_stat.acq_readout_pause, acq_stat.fill_type, acq_stat.chan_en};

  assign status_regs[9]  = {27'd0, acq_stat.trig_settings, acq_stat.acq_fifo_full,
                            acq_stat.trig_fifo_full};
  assign status_regs[10] = board_stat.trig_delay;

  // Trigger counts and the 44-bit timestamp split over two words
  assign status_regs[11] = {8'd0, trig_info.trig_num};
  assign status_regs[12] = trig_info.trig_timestamp[31:0];
  assign status_regs[13] = {20'd0, trig_info.trig_timestamp[43:32]};
  assign status_regs[14] = {8'd0, trig_info.pulse_trig_num};

  // Threshold then count, per soft error
  assign status_regs[15] = soft_err.data_corrupt_thres;
  assign status_regs[16] = soft_err.data_corrupt_count;
  assign status_regs[17] = soft_err.unknown_ttc_thres;
  assign status_regs[18] = soft_err.unknown_ttc_count;
  assign status_regs[19] = soft_err.ddr3_overflow_thres;
  assign status_regs[20] = soft_err.ddr3_overflow_count;

endmodule

/* hdl/status_read_port.sv */
`timescale 1ns/10ps
`include "rider_status_cfg.svh"

module status_read_port (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req,
  input  regbus_pkg::rd_req_t  rd_req,
  input  logic [31:0]          status_regs [`STATUS_REG_COUNT],
  output logic                 ack,
  output regbus_pkg::rd_rsp_t  rd_rsp
);

  logic        addr_ok;
  logic [31:0] sel_word;
  logic        start;

  // New request seen, response not yet given
  assign start = req && !ack;

  // Address decode with out-of-range check
  assign addr_ok = (int'(rd_req.addr) < `STATUS_REG_COUNT);

  always_comb begin
    sel_word = 32'd0;
    for (int i = 0; i < `STATUS_REG_COUNT; i++) begin
      if (int'(rd_req.addr) == i) begin
        sel_word = status_regs[i];
      end
    end
  end

  // Four-phase handshake
  always_ff @(posedge clk) begin
    if (reset) begin
      ack <= 1'b0;
    end else if (start) begin
      ack <= 1'b1;
    end else if (!req) begin
      ack <= 1'b0;
    end
  end

  // Snapshot at the start, held while ack is high
  always_ff @(posedge clk) begin
    if (start) begin
      rd_rsp.rdata <= addr_ok ? sel_word : 32'd0;
      rd_rsp.err   <= !addr_ok;
    end
  end

endmodule

/* hdl/rider_status_top.sv */
`timescale 1ns/10ps
`include "rider_status_cfg.svh"

module rider_status_top (
  input  logic                    clk,
  input  logic                    reset,
  input  status_pkg::hard_err_t   hard_err,
  input  status_pkg::clk_stat_t   clk_stat,
  input  status_pkg::link_stat_t  link_stat,
  input  status_pkg::fsm_stat_t   fsm_stat,
  input  status_pkg::acq_stat_t   acq_stat,
  input  status_pkg::board_stat_t board_stat,
  input  logic                    cs_mismatch,
  input  logic                    unknown_cmd,
  input  logic                    ddr3_overflow,
  input  logic                    trig,
  input  logic                    pulse_trig,
  input  logic [31:0]             thres_data_corrupt,
  input  logic [31:0]             thres_unknown_ttc,
  input  logic [31:0]             thres_ddr3_overflow,
  input  logic                    req,
  input  regbus_pkg::rd_req_t     rd_req,
  output logic                    ack,
  output regbus_pkg::rd_rsp_t     rd_rsp
);

  status_pkg::soft_err_t  soft_err;
  status_pkg::trig_info_t trig_info;
  logic                   err_data_corrupt;
  logic                   err_unknown_ttc;
  logic                   ddr3_overflow_warning;
  logic [31:0]            status_regs [`STATUS_REG_COUNT];

  // Host thresholds go straight into the map
  assign soft_err.data_corrupt_thres  = thres_data_corrupt;
  assign soft_err.unknown_ttc_thres   = thres_unknown_ttc;
  assign soft_err.ddr3_overflow_thres = thres_ddr3_overflow;

  // Checksum mismatches count as data corruption
  soft_error_counter u_data_corrupt (
    .clk         (clk),
    .reset       (reset),
    .event_pulse (cs_mismatch),
    .threshold   (thres_data_corrupt),
    .count       (soft_err.data_corrupt_count),
    .flag        (err_data_corrupt)
  );

  soft_error_counter u_unknown_ttc (
    .clk         (clk),
    .reset       (reset),
    .event_pulse (unknown_cmd),
    .threshold   (thres_unknown_ttc),
    .count       (soft_err.unknown_ttc_count),
    .flag        (err_unknown_ttc)
  );

  // Only a warning, not a hard error
  soft_error_counter u_ddr3_overflow (
    .clk         (clk),
    .reset       (reset),
    .event_pulse (ddr3_overflow),
    .threshold   (thres_ddr3_overflow),
    .count       (soft_err.ddr3_overflow_count),
    .flag        (ddr3_overflow_warning)
  );

  trigger_tracker u_trigger_tracker (
    .clk        (clk),
    .reset      (reset),
    .trig       (trig),
    .pulse_trig (pulse_trig),
    .info       (trig_info)
  );

  status_reg_block u_status_reg_block (
    .hard_err              (hard_err),
    .clk_stat              (clk_stat),
    .link_stat             (link_stat),
    .fsm_stat              (fsm_stat),
    .acq_stat              (acq_stat),
    .board_stat            (board_stat),
    .soft_err              (soft_err),
    .trig_info             (trig_info),
    .err_data_corrupt      (err_data_corrupt),
    .err_unknown_ttc       (err_unknown_ttc),
    .ddr3_overflow_warning (ddr3_overflow_warning),
    .status_regs           (status_regs)
  );

  status_read_port u_status_read_port (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .rd_req      (rd_req),
    .status_regs (status_regs),
    .ack         (ack),
    .rd_rsp      (rd_rsp)
  );

endmodule

/* dv/rider_status_tb.sv */
`timescale 1ns/10ps
`include "rider_status_cfg.svh"

module rider_status_tb;

  localparam int NUM_ROWS   = 4;
  localparam int ROW_CYCLES = 200;
  localparam int CLK_PERIOD = 100;
  localparam int PULSE_WIN  = 64;

  typedef struct packed {
    status_pkg::hard_err_t   hard;
    status_pkg::clk_stat_t   clks;
    status_pkg::link_stat_t  link;
    status_pkg::fsm_stat_t   fsm;
    status_pkg::acq_stat_t   acq;
    status_pkg::board_stat_t board;
    logic [7:0]              n_dc;
    logic [7:0]              n_ttc;
    logic [7:0]              n_ddr;
    logic [31:0]             t_dc;
    logic [31:0]             t_ttc;
    logic [31:0]             t_ddr;
    logic [7:0]              n_trig;
    logic [7:0]              n_ptrig;
  } row_t;

  logic                    clk = 1'b0;
  logic                    reset;
  status_pkg::hard_err_t   hard_err;
  status_pkg::clk_stat_t   clk_stat;
  status_pkg::link_stat_t  link_stat;
  status_pkg::fsm_stat_t   fsm_stat;
  status_pkg::acq_stat_t   acq_stat;
  status_pkg::board_stat_t board_stat;
  logic                    pulse [3];
  logic [31:0]             thr [3];
  logic                    trig;
  logic                    pulse_trig;
  logic                    req;
  regbus_pkg::rd_req_t     rd_req;
  logic                    ack;
  regbus_pkg::rd_rsp_t     rd_rsp;

  // Reference model state
  logic [31:0] cnt [3];
  logic        flag [3];
  logic [23:0] trig_cnt;
  logic [23:0] ptrig_cnt;
  logic [43:0] tsc;
  logic [43:0] ts_exp;

  row_t tbl [NUM_ROWS];
  int   seed = 41875;
  int   errors = 0;
  int   tests_run = 0;
  int   tests_failed = 0;
  bit   test_ok;

  rider_status_top dut (
    .clk                 (clk),
    .reset               (reset),
    .hard_err            (hard_err),
    .clk_stat            (clk_stat),
    .link_stat           (link_stat),
    .fsm_stat            (fsm_stat),
    .acq_stat            (acq_stat),
    .board_stat          (board_stat),
    .cs_mismatch         (pulse[0]),
    .unknown_cmd         (pulse[1]),
    .ddr3_overflow       (pulse[2]),
    .trig                (trig),
    .pulse_trig          (pulse_trig),
    .thres_data_corrupt  (thr[0]),
    .thres_unknown_ttc   (thr[1]),
    .thres_ddr3_overflow (thr[2]),
    .req                 (req),
    .rd_req              (rd_req),
    .ack                 (ack),
    .rd_rsp              (rd_rsp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #((NUM_ROWS * ROW_CYCLES + 200) * CLK_PERIOD);
    $display("Timeout: the watchdog stopped a run that did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  // One clock edge, model updated from the inputs driven before it
  task automatic step();
    @(posedge clk);
    if (reset) begin
      for (int i = 0; i < 3; i++) begin
        cnt[i]  = 32'd0;
        flag[i] = 1'b0;
      end
      trig_cnt  = 24'd0;
      ptrig_cnt = 24'd0;
      tsc       = 44'd0;
      ts_exp    = 44'd0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (pulse[i] && cnt[i] != 32'hffff_ffff) begin
          cnt[i] = cnt[i] + 32'd1;
        end
        if (thr[i] != 32'd0 && cnt[i] >= thr[i]) begin
          flag[i] = 1'b1;
        end
      end
      if (trig) begin
        trig_cnt = trig_cnt + 24'd1;
        ts_exp   = tsc;
      end
      if (pulse_trig) begin
        ptrig_cnt = ptrig_cnt + 24'd1;
      end
      tsc = tsc + 44'd1;
    end
    @(negedge clk);
  endtask

  task automatic check(input bit cond, input string msg);
    assert (cond) else begin
      $display("FAIL t=%0t %s", $time, msg);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  function automatic logic [31:0] expect_word(input int idx);
    case (idx)
      0: return {1'b0, board_stat.prog_chan_done, board_stat.async_mode, 5'd0,
                 `MAJOR_REV, `MINOR_REV, `PATCH_REV};
      1: return {18'd0, flag[2], hard_err.chan_error_rc, hard_err.trig_type_from_cm,
                 hard_err.trig_type_from_tt, hard_err.trig_num_from_cm,
                 hard_err.trig_num_from_tt, flag[0], hard_err.trig_rate, flag[1],
                 hard_err.pll_unlock};
      2: return {board_stat.i2c_temp, 18'd0, clk_stat.daq_clk_sel, clk_stat.daq_clk_en};
      3: return {28'd0, clk_stat.adcclk_clkin1_stat, clk_stat.adcclk_clkin0_stat,
                 clk_stat.adcclk_stat_ld, clk_stat.adcclk_stat};
      4: return {30'd0, link_stat.daq_almost_full, link_stat.daq_ready};
      5: return {21'd0, link_stat.tts_state, link_stat.ttc_chan_b_info, link_stat.ttc_ready};
      6: return fsm_stat.cm_state[31:0];
      7: return {3'd0, fsm_stat.cm_state[33:32], fsm_stat.pc, fsm_stat.tp, fsm_stat.caca,
                 fsm_stat.cac, fsm_stat.ptr, fsm_stat.ttr};
      8: return {11'd0, acq_stat.acq_dones, acq_stat.endianness_sel,
                 acq_stat.acq_readout_pause, acq_stat.fill_type, acq_stat.chan_en};
      9: return {27'd0, acq_stat.trig_settings, acq_stat.acq_fifo_full,
                 acq_stat.trig_fifo_full};
      10: return board_stat.trig_delay;
      11: return {8'd0, trig_cnt};
      12: return ts_exp[31:0];
      13: return {20'd0, ts_exp[43:32]};
      14: return {8'd0, ptrig_cnt};
      15: return thr[0];
      16: return cnt[0];
      17: return thr[1];
      18: return cnt[1];
      19: return thr[2];
      20: return cnt[2];
      default: return 32'd0;
    endcase
  endfunction

  // Four-phase read, optionally holding req for extra cycles
  task automatic read_word(input int addr, input int hold, output logic [31:0] data);
    logic [31:0] exp;
    bit          exp_err;
    int          waited;
    exp_err     = (addr >= `STATUS_REG_COUNT);
    exp         = exp_err ? 32'd0 : expect_word(addr);
    rd_req.addr = 5'(addr);
    req         = 1'b1;
    waited      = 0;
    data        = 32'd0;
    do begin
      step();
      waited++;
    end while (!ack && waited < 8);
    if (!ack) begin
      $display("Timeout: the DUT never acknowledged the read of address %0d", addr);
      $display("=== FAIL ===");
      $finish;
    end else begin
      check(waited == 1, $sformatf("addr %0d ack after %0d cycles", addr, waited));
      check(rd_rsp.err == exp_err, $sformatf("addr %0d err %0b expected %0b",
                                             addr, rd_rsp.err, exp_err));
      check(rd_rsp.rdata == exp, $sformatf("addr %0d rdata %h expected %h",
                                           addr, rd_rsp.rdata, exp));
      data = rd_rsp.rdata;
      for (int i = 0; i < hold; i++) begin
        board_stat = ~board_stat;
        clk_stat   = ~clk_stat;
        step();
        check(ack == 1'b1, "ack dropped while req was held");
        check(rd_rsp.rdata == exp && rd_rsp.err == exp_err, "response changed under ack");
      end
      req = 1'b0;
      step();
      check(ack == 1'b0, $sformatf("addr %0d ack still high after req fell", addr));
    end
  endtask

  task automatic start_test();
    test_ok = 1'b1;
    tests_run++;
  endtask

  task automatic finish_test(input string name);
    if (!test_ok) begin
      tests_failed++;
    end
    $display("test %0d %s: %s", tests_run, name, test_ok ? "passed" : "failed");
  endtask

  task automatic set_counts(input int r, input int n0, input int n1, input int n2,
                            input int t0, input int t1, input int t2,
                            input int nt, input int np);
    tbl[r].n_dc    = 8'(n0);
    tbl[r].n_ttc   = 8'(n1);
    tbl[r].n_ddr   = 8'(n2);
    tbl[r].t_dc    = 32'(t0);
    tbl[r].t_ttc   = 32'(t1);
    tbl[r].t_ddr   = 32'(t2);
    tbl[r].n_trig  = 8'(nt);
    tbl[r].n_ptrig = 8'(np);
  endtask

  // Random placement of a known number of pulses per source
  task automatic run_pulses(input int r);
    int  rem [5];
    rem = '{int'(tbl[r].n_dc), int'(tbl[r].n_ttc), int'(tbl[r].n_ddr),
            int'(tbl[r].n_trig), int'(tbl[r].n_ptrig)};
    for (int c = 0; c < PULSE_WIN; c++) begin
      for (int i = 0; i < 5; i++) begin
        logic fire;
        fire = (rem[i] > 0) && ((($random(seed) & 1) != 0) || rem[i] >= PULSE_WIN - c);
        if (fire) begin
          rem[i]--;
        end
        case (i)
          0, 1, 2: pulse[i] = fire;
          3:       trig = fire;
          default: pulse_trig = fire;
        endcase
      end
      step();
    end
    pulse      = '{1'b0, 1'b0, 1'b0};
    trig       = 1'b0;
    pulse_trig = 1'b0;
    step();
  endtask

  initial begin
    logic [63:0] rnd;
    logic [31:0] d;
    reset      = 1'b1;
    hard_err   = '0;
    clk_stat   = '0;
    link_stat  = '0;
    fsm_stat   = '0;
    acq_stat   = '0;
    board_stat = '0;
    pulse      = '{1'b0, 1'b0, 1'b0};
    thr        = '{32'd0, 32'd0, 32'd0};
    trig       = 1'b0;
    pulse_trig = 1'b0;
    req        = 1'b0;
    rd_req     = '0;

    for (int r = 0; r < NUM_ROWS; r++) begin
      rnd = {$random(seed), $random(seed)};
      tbl[r].hard  = rnd[10:0];
      tbl[r].clks  = rnd[16:11];
      tbl[r].link  = rnd[29:17];
      tbl[r].acq   = rnd[56:30];
      rnd = {$random(seed), $random(seed)};
      tbl[r].fsm   = rnd[60:0];
      rnd = {$random(seed), $random(seed)};
      tbl[r].board = rnd[45:0];
    end
    // Row 1 raises the data corruption threshold above its count
    set_counts(0, 5, 3, 7, 4, 10, 0, 3, 2);
    set_counts(1, 6, 8, 2, 20, 10, 9, 5, 1);
    set_counts(2, 0, 0, 0, 0, 0, 0, 0, 0);
    set_counts(3, 4, 2, 1, 1, 40, 100, 2, 6);

    repeat (5) step();
    reset = 1'b0;
    step();

    start_test();
    check(ack == 1'b0, "ack high after reset");
    read_word(0, 0, d);
    check(d[23:0] == {`MAJOR_REV, `MINOR_REV, `PATCH_REV}, "revision wrong in word 0");
    for (int w = 11; w <= 20; w++) begin
      if (w <= 14 || w == 16 || w == 18 || w == 20) begin
        read_word(w, 0, d);
        check(d == 32'd0, $sformatf("word %0d not zero after reset", w));
      end
    end
    finish_test("reset state");

    for (int r = 0; r < NUM_ROWS; r++) begin
      hard_err   = tbl[r].hard;
      clk_stat   = tbl[r].clks;
      link_stat  = tbl[r].link;
      fsm_stat   = tbl[r].fsm;
      acq_stat   = tbl[r].acq;
      board_stat = tbl[r].board;
      thr        = '{tbl[r].t_dc, tbl[r].t_ttc, tbl[r].t_ddr};
      step();

      start_test();
      for (int w = 2; w <= 10; w++) begin
        read_word(w, 0, d);
      end
      finish_test($sformatf("row %0d static words", r));

      start_test();
      run_pulses(r);
      read_word(1, 0, d);
      check({d[3], d[1], d[13]} == {flag[0], flag[1], flag[2]}, "flag bits wrong");
      for (int w = 15; w <= 20; w++) begin
        read_word(w, 0, d);
      end
      finish_test($sformatf("row %0d soft errors", r));

      start_test();
      for (int w = 11; w <= 14; w++) begin
        read_word(w, 0, d);
      end
      finish_test($sformatf("row %0d triggers", r));
    end

    start_test();
    read_word(21, 0, d);
    read_word(31, 0, d);
    read_word(5, 0, d);
    finish_test("address decode");

    start_test();
    read_word(2, 4, d);
    finish_test("held request");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+hdl
hdl/status_pkg.sv
hdl/regbus_pkg.sv
hdl/soft_error_counter.sv
hdl/trigger_tracker.sv
hdl/status_reg_block.sv
hdl/status_read_port.sv
hdl/rider_status_top.sv
dv/rider_status_tb.sv

/* Makefile */
# Verilator build and run of the status path testbench

VERILATOR ?= verilator
TOP       ?= rider_status_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "=== PASS ===" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
